/* aes_pipe.f */
+incdir+include
hdl/aes_pkg.sv
hdl/aes_whiten.sv
hdl/aes_key_step.sv
hdl/aes_round_stage.sv
hdl/aes_final_stage.sv
hdl/aes_pipe_top.sv
dv/aes_pipe_tb.sv

/* include/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Software AES-128, one block at a time
////////////////////////////////////////////////////////////////////////////

// SubBytes then ShiftRows, byte 0 in the top bits, column-major order
function automatic logic [127:0] ref_sub_shift(input logic [127:0] s);
    logic [127:0] r;
    r = '0;
    for (int c = 0; c < 4; c++)
    begin
        for (int row = 0; row < 4; row++)
        begin
            r[127-8*(4*c+row) -: 8] = aes_pkg::sbox[s[127-8*(4*((c+row)%4)+row) -: 8]];
        end
    end
    return r;
endfunction

function automatic logic [127:0] ref_mix_columns(input logic [127:0] s);
    logic [127:0] r;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;
    r = '0;
    for (int c = 0; c < 4; c++)
    begin
        a0 = s[127-32*c -: 8];
        a1 = s[119-32*c -: 8];
        a2 = s[111-32*c -: 8];
        a3 = s[103-32*c -: 8];
        r[127-32*c -: 32] = {
            aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
            aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)};
    end
    return r;
endfunction

// Key for round rnd from the key of round rnd - 1
function automatic logic [127:0] ref_key_next(input logic [127:0] k, input int rnd);
    logic [31:0] t;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    t = {aes_pkg::sbox[k[23:16]], aes_pkg::sbox[k[15:8]],
         aes_pkg::sbox[k[7:0]], aes_pkg::sbox[k[31:24]]};
    t[31:24] = t[31:24] ^ aes_pkg::rcon[rnd-1];
    w0 = k[127:96] ^ t;
    w1 = k[95:64] ^ w0;
    w2 = k[63:32] ^ w1;
    w3 = k[31:0] ^ w2;
    return {w0, w1, w2, w3};
endfunction

function automatic logic [127:0] ref_encrypt(input logic [127:0] pt, input logic [127:0] key);
    logic [127:0] s;
    logic [127:0] k;
    s = pt ^ key;
    k = key;
    for (int rnd = 1; rnd <= aes_pkg::num_rounds; rnd++)
    begin
        k = ref_key_next(k, rnd);
        s = ref_sub_shift(s);
        if (rnd < aes_pkg::num_rounds)
            s = ref_mix_columns(s);
        s = s ^ k;
    end
    return s;
endfunction

`endif

/* dv/aes_pipe_tb.sv */
`timescale 1ns/1ns

module aes_pipe_tb;

    logic         clk = 1'b0;
    logic         rst;
    logic         in_valid;
    logic [127:0] plaintext;
    logic [127:0] key;
    logic         out_valid;
    logic [127:0] ciphertext;

    // Blocks over all tests set the timeout
    int total_blocks = 1 + 200 + 200 + 64 + 30 + 40;
    int slack_cycles = 100;

    int  cycle = 0;
    int  err_count = 0;
    int  check_count = 0;
    int  test_count = 0;
    int  sent_count = 0;
    int  sent_mark = 0;
    int  err_mark = 0;
    logic checking = 1'b0;

    // Scoreboard queues
    // Issue is the cycle count seen at the edge that drove the block
    logic [127:0] exp_q [$];
    int           issue_q [$];
    logic [127:0] got_exp;
    int           got_issue;

    // Expected out_valid is in_valid seen through the pipeline depth
    logic [aes_pkg::pipe_latency-1:0] valid_line = '0;

    `include "aes_ref_model.svh"

    aes_pipe_top uut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    function automatic logic [127:0] random_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic send_block(input logic [127:0] pt, input logic [127:0] k,
                              input logic [127:0] ct);
        @(posedge clk);
        in_valid <= 1'b1;
        plaintext <= pt;
        key <= k;
        exp_q.push_back(ct);
        issue_q.push_back(cycle);
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        plaintext <= random_block();
        key <= random_block();
    endtask

    task automatic drain_pipe();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_q.size() != 0 && waited < aes_pkg::pipe_latency + 2)
        begin
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d blocks, %0d errors", name, sent_count - sent_mark,
                 err_count - err_mark);
        sent_mark = sent_count;
        err_mark = err_count;
        test_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Cycle count, timeout and output monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= (total_blocks + aes_pkg::pipe_latency + 10 + slack_cycles) * 2)
        begin
            $display("Timeout after %0d cycles, %0d blocks still expected", cycle,
                     exp_q.size());
            $display("Finished with errors");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        if (rst)
            valid_line <= '0;
        else
            valid_line <= {valid_line[aes_pkg::pipe_latency-2:0], in_valid};
    end

    // Outputs were loaded one edge back
    always @(posedge clk)
    begin
        if (checking)
        begin
            check_value("out_valid", 128'(out_valid),
                        128'(valid_line[aes_pkg::pipe_latency-1]));
            if (out_valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("ERROR at %0t ns: out_valid is high but no block was expected",
                             $time);
                    err_count++;
                end
                else
                begin
                    got_exp = exp_q.pop_front();
                    got_issue = issue_q.pop_front();
                    check_value("ciphertext", ciphertext, got_exp);
                    check_value("latency", 128'(cycle - 1 - got_issue),
                                128'(aes_pkg::pipe_latency));
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [127:0] pt;
        logic [127:0] k;
        logic [127:0] kat_key;
        logic [127:0] kat_pt;
        logic [127:0] kat_ct;
        int           dropped;

        void'($urandom(68856));
        kat_key = 128'h000102030405060708090a0b0c0d0e0f;
        kat_pt = 128'h00112233445566778899aabbccddeeff;
        kat_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        rst <= 1'b1;
        in_valid <= 1'b0;
        plaintext <= '0;
        key <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        checking <= 1'b1;

        // FIPS-197 example vector
        check_value("model known answer", ref_encrypt(kat_pt, kat_key), kat_ct);
        send_block(kat_pt, kat_key, kat_ct);
        drain_pipe();
        finish_test("known_answer");

        repeat (200)
        begin
            pt = random_block();
            k = random_block();
            send_block(pt, k, ref_encrypt(pt, k));
        end
        drain_pipe();
        finish_test("full_throughput");

        repeat (200)
        begin
            pt = random_block();
            k = random_block();
            if (($urandom & 1) == 1)
                send_block(pt, k, ref_encrypt(pt, k));
            else
                idle_cycle();
        end
        drain_pipe();
        finish_test("sparse_valid");

        // Same plaintext with a new key each cycle
        pt = 128'h3243f6a8885a308d313198a2e0370734;
        repeat (64)
        begin
            k = random_block();
            send_block(pt, k, ref_encrypt(pt, k));
        end
        drain_pipe();
        finish_test("key_per_block");

        repeat (30)
        begin
            pt = random_block();
            k = random_block();
            send_block(pt, k, ref_encrypt(pt, k));
        end
        @(posedge clk);
        rst <= 1'b1;
        in_valid <= 1'b0;
        repeat (10) @(posedge clk);
        // Blocks still in the pipe were flushed by reset
        dropped = exp_q.size();
        exp_q.delete();
        issue_q.delete();
        // Only blocks driven in the last pipe_latency - 1 cycles had not come out
        check_value("blocks flushed by reset", 128'(dropped),
                    128'(aes_pkg::pipe_latency - 1));
        rst <= 1'b0;
        repeat (aes_pkg::pipe_latency) idle_cycle();
        repeat (40)
        begin
            pt = random_block();
            k = random_block();
            send_block(pt, k, ref_encrypt(pt, k));
        end
        drain_pipe();
        finish_test("reset_flush");

        if (exp_q.size() != 0)
        begin
            $display("ERROR: %0d expected blocks never came out", exp_q.size());
            err_count++;
        end
        $display("%0d tests, %0d blocks, %0d checks, %0d errors", test_count, sent_count,
                 check_count, err_count);
        if (err_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* hdl/aes_final_stage.sv */
`timescale 1ns/1ns

module aes_final_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  aes_pkg::aes_block_u         state_in,
    input  aes_pkg::aes_block_u         key_in,
    input  logic                        valid_in,
    output logic [aes_pkg::block_w-1:0] ciphertext,
    output logic                        out_valid
);

    logic [aes_pkg::byte_w-1:0] sb_q [16];
    aes_pkg::aes_block_u        shifted;
    aes_pkg::aes_block_u        round_key;
    logic                       valid_q;

    // Last expansion step, its next key has no consumer
    aes_key_step #(
        .round_index (aes_pkg::num_rounds)
    ) u_key_step (
        .clk       (clk),
        .key_in    (key_in),
        .round_key (round_key),
        .key_next  ()
    );

    ////////////////////////////////////////////////////////////////////////////
    // SubBytes, ShiftRows, AddRoundKey
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 16; i++)
        begin
            sb_q[i] <= aes_pkg::sbox[state_in.bytes[i]];
        end
    end

    // Row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted.bytes[4*c+r] = sb_q[4*((c+r)%4)+r];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        ciphertext <= shifted ^ round_key;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_q <= valid_in;
            out_valid <= valid_q;
        end
    end

endmodule

/* hdl/aes_key_step.sv */
`timescale 1ns/1ns

module aes_key_step #(
    parameter int round_index = 1
) (
    input  logic                clk,
    input  aes_pkg::aes_block_u key_in,
    output aes_pkg::aes_block_u round_key,
    output aes_pkg::aes_block_u key_next
);

    aes_pkg::aes_block_u           prefix_d;
    aes_pkg::aes_block_u           prefix_q;
    logic [aes_pkg::word_w-1:0]    sub_q;

    ////////////////////////////////////////////////////////////////////////////
    // First cycle
    ////////////////////////////////////////////////////////////////////////////

    // Running XOR of the old words, rcon folded into word 0
    always_comb
    begin
        prefix_d.words[0] = key_in.words[0]
                          ^ {aes_pkg::rcon[round_index-1], {(aes_pkg::word_w-8){1'b0}}};
        for (int i = 1; i < 4; i++)
        begin
            prefix_d.words[i] = prefix_d.words[i-1] ^ key_in.words[i];
        end
    end

    // SubWord(RotWord(w3)), the last word is bytes 12 to 15
    always_ff @(posedge clk)
    begin
        prefix_q <= prefix_d;
        sub_q <= {aes_pkg::sbox[key_in.bytes[13]],
                  aes_pkg::sbox[key_in.bytes[14]],
                  aes_pkg::sbox[key_in.bytes[15]],
                  aes_pkg::sbox[key_in.bytes[12]]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Second cycle
    ////////////////////////////////////////////////////////////////////////////

    // Every word of the new key carries the substituted word once
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            round_key.words[i] = prefix_q.words[i] ^ sub_q;
        end
    end

    always_ff @(posedge clk)
    begin
        key_next <= round_key;
    end

endmodule

/* hdl/aes_pipe_top.sv */
`timescale 1ns/1ns

module aes_pipe_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [aes_pkg::block_w-1:0] plaintext,
    input  logic [aes_pkg::block_w-1:0] key,
    output logic                        out_valid,
    output logic [aes_pkg::block_w-1:0] ciphertext
);

    // Index 0 is the whitening output, index i the output of round i
    aes_pkg::aes_block_u stage_state [0:aes_pkg::num_rounds-1];
    aes_pkg::aes_block_u stage_key [0:aes_pkg::num_rounds-1];
    logic                stage_valid [0:aes_pkg::num_rounds-1];

    aes_whiten u_whiten (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .plaintext (plaintext),
        .key       (key),
        .state_out (stage_state[0]),
        .key_out   (stage_key[0]),
        .valid_out (stage_valid[0])
    );

    // Nine full rounds
    for (genvar i = 1; i < aes_pkg::num_rounds; i++)
    begin : g_round
        aes_round_stage #(
            .round_index (i)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .state_in  (stage_state[i-1]),
            .key_in    (stage_key[i-1]),
            .valid_in  (stage_valid[i-1]),
            .state_out (stage_state[i]),
            .key_out   (stage_key[i]),
            .valid_out (stage_valid[i])
        );
    end

    aes_final_stage u_final (
        .clk        (clk),
        .rst        (rst),
        .state_in   (stage_state[aes_pkg::num_rounds-1]),
        .key_in     (stage_key[aes_pkg::num_rounds-1]),
        .valid_in   (stage_valid[aes_pkg::num_rounds-1]),
        .ciphertext (ciphertext),
        .out_valid  (out_valid)
    );

endmodule

/* hdl/aes_pkg.sv */
package aes_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and pipeline shape
    ////////////////////////////////////////////////////////////////////////////

    localparam int block_w = 128;
    localparam int word_w = 32;
    localparam int byte_w = 8;

    localparam int num_rounds = 10;
    localparam int stage_latency = 2;

    // Whitening register, nine full rounds, then the final round
    localparam int pipe_latency = 1 + (num_rounds - 1) * stage_latency + stage_latency;

    ////////////////////////////////////////////////////////////////////////////
    // Tables
    ////////////////////////////////////////////////////////////////////////////

    // Forward S-box
    localparam logic [byte_w-1:0] sbox [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Round constants, entry 0 belongs to round 1
    localparam logic [byte_w-1:0] rcon [num_rounds] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [byte_w-1:0] xtime(input logic [byte_w-1:0] b);
        return {b[byte_w-2:0], 1'b0} ^ (b[byte_w-1] ? 8'h1b : 8'h00);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Block views
    ////////////////////////////////////////////////////////////////////////////

    // Index 0 is the most significant word or byte in both views
    typedef union packed {
        logic [0:3][word_w-1:0] words;
        logic [0:15][byte_w-1:0] bytes;
    } aes_block_u;

endpackage

/* hdl/aes_round_stage.sv */
`timescale 1ns/1ns

module aes_round_stage #(
    parameter int round_index = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  aes_pkg::aes_block_u state_in,
    input  aes_pkg::aes_block_u key_in,
    input  logic                valid_in,
    output aes_pkg::aes_block_u state_out,
    output aes_pkg::aes_block_u key_out,
    output logic                valid_out
);

    logic [aes_pkg::byte_w-1:0] sb_d [16];
    logic [aes_pkg::byte_w-1:0] s1_q [16];
    logic [aes_pkg::byte_w-1:0] s2_q [16];
    logic [aes_pkg::byte_w-1:0] s3_q [16];
    aes_pkg::aes_block_u        mix;
    aes_pkg::aes_block_u        round_key;
    logic                       valid_q;

    aes_key_step #(
        .round_index (round_index)
    ) u_key_step (
        .clk       (clk),
        .key_in    (key_in),
        .round_key (round_key),
        .key_next  (key_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Table lookups
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            sb_d[i] = aes_pkg::sbox[state_in.bytes[i]];
        end
    end

    // S, 2.S and 3.S per byte, the T-table columns
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 16; i++)
        begin
            s1_q[i] <= sb_d[i];
            s2_q[i] <= aes_pkg::xtime(sb_d[i]);
            s3_q[i] <= aes_pkg::xtime(sb_d[i]) ^ sb_d[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // MixColumns along the ShiftRows diagonals
    ////////////////////////////////////////////////////////////////////////////

    // Row r of output column c comes from input column (c + r) mod 4
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mix.bytes[4*c+0] = s2_q[4*c] ^ s3_q[4*((c+1)%4)+1]
                             ^ s1_q[4*((c+2)%4)+2] ^ s1_q[4*((c+3)%4)+3];
            mix.bytes[4*c+1] = s1_q[4*c] ^ s2_q[4*((c+1)%4)+1]
                             ^ s3_q[4*((c+2)%4)+2] ^ s1_q[4*((c+3)%4)+3];
            mix.bytes[4*c+2] = s1_q[4*c] ^ s1_q[4*((c+1)%4)+1]
                             ^ s2_q[4*((c+2)%4)+2] ^ s3_q[4*((c+3)%4)+3];
            mix.bytes[4*c+3] = s3_q[4*c] ^ s1_q[4*((c+1)%4)+1]
                             ^ s1_q[4*((c+2)%4)+2] ^ s2_q[4*((c+3)%4)+3];
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= mix ^ round_key;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
            valid_out <= 1'b0;
        end
        else
        begin
            valid_q <= valid_in;
            valid_out <= valid_q;
        end
    end

endmodule

/* hdl/aes_whiten.sv */
`timescale 1ns/1ns

module aes_whiten (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [aes_pkg::block_w-1:0] plaintext,
    input  logic [aes_pkg::block_w-1:0] key,
    output aes_pkg::aes_block_u         state_out,
    output aes_pkg::aes_block_u         key_out,
    output logic                        valid_out
);

    // Round 0 AddRoundKey, the cipher key itself seeds the expansion
    always_ff @(posedge clk)
    begin
        state_out <= plaintext ^ key;
        key_out <= key;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_out <= 1'b0;
        else
            valid_out <= in_valid;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module aes_pipe_tb -f aes_pipe.f -o aes_pipe_sim \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/aes_pipe_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" \
    && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
